// ==== design/serial_link_consts.svh ====
// Link and PHY sizing constants: lane count, widths, credits and queue depths
`ifndef SERIAL_LINK_CONSTS_SVH
`define SERIAL_LINK_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Physical layer
//////////////////////////////////////////////////////////////////////

// Lanes driven in parallel per chunk
`define SL_NUM_LANES 8

// Width of the divider input
`define SL_CLK_DIV_BITS 8

// Chunks needed for one padded frame
`define SL_FRAME_SPLITS 3

//////////////////////////////////////////////////////////////////////
// Link layer
//////////////////////////////////////////////////////////////////////

`define SL_DATA_BITS 16

// Receive buffer slots, one credit each
`define SL_NUM_CREDITS 4
`define SL_CREDIT_BITS 3

// Frames waiting in front of the serializer
`define SL_TX_FIFO_DEPTH 2

`endif

// ==== design/serial_link_fifo.sv ====
// Generic FIFO with a type parameter and a head visible before pop
module serial_link_fifo #(
  parameter type item_t = logic,
  parameter int  Depth  = 2
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  item_t data_i,
  output logic  full_o,
  input  logic  pop_i,
  output item_t data_o,
  output logic  empty_o
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  typedef logic [PtrBits-1:0] ptr_t;

  item_t              mem_q [Depth];
  ptr_t               rd_ptr_q;
  ptr_t               wr_ptr_q;
  logic [CntBits-1:0] count_q;
  logic               do_push;
  logic               do_pop;

  // Wraps at Depth so non power-of-two depths work
  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntBits'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== design/serial_link_pkg.sv ====
// Link-layer types: user data word, credit count, header tag and link frame
`include "serial_link_consts.svh"

package serial_link_pkg;

  // User payload word
  typedef logic [`SL_DATA_BITS-1:0] data_t;

  // Holds 0 up to the full credit pool
  typedef logic [`SL_CREDIT_BITS-1:0] credit_t;

  // Header tag of a frame
  typedef enum logic [1:0] {
    TAG_IDLE   = 2'd0,
    TAG_DATA   = 2'd1,
    TAG_CREDIT = 2'd2
  } tag_e;

  // One link frame, data in the upper bits
  // Credit-only frames leave the data field unused
  typedef struct packed {
    data_t   data;
    tag_e    tag;
    credit_t credit;
  } frame_t;

endpackage

// ==== design/serial_link_rx_ctrl.sv ====
// Receive controller: data buffer, credit return and received credit forwarding
`include "serial_link_consts.svh"

module serial_link_rx_ctrl import serial_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // From the deserializer
  input  frame_t  frame_i,
  input  logic    frame_valid_i,
  // User stream
  output data_t   rx_data_o,
  output logic    rx_valid_o,
  input  logic    rx_ready_i,
  // To the transmit controller
  output logic    credit_ret_o,
  output logic    credit_rcvd_o,
  output credit_t credit_rcvd_cnt_o
);

  logic fifo_full;
  logic fifo_empty;
  logic push;
  logic pop;

  // Space is guaranteed by the credits granted to the far end
  assign push = frame_valid_i && (frame_i.tag == TAG_DATA) && !fifo_full;
  assign pop  = rx_valid_o && rx_ready_i;

  assign rx_valid_o = !fifo_empty;

  serial_link_fifo #(
    .item_t ( data_t          ),
    .Depth  ( `SL_NUM_CREDITS )
  ) i_rx_fifo (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .push_i  ( push         ),
    .data_i  ( frame_i.data ),
    .full_o  ( fifo_full    ),
    .pop_i   ( pop          ),
    .data_o  ( rx_data_o    ),
    .empty_o ( fifo_empty   )
  );

  //////////////////////////////////////////////////////////////////////
  // Credit pulses
  //////////////////////////////////////////////////////////////////////

  // Each pop frees one slot, owed to the far end
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_ret_o  <= 1'b0;
      credit_rcvd_o <= 1'b0;
    end else begin
      credit_ret_o  <= pop;
      credit_rcvd_o <= frame_valid_i && (frame_i.tag != TAG_IDLE);
    end
  end

  // Count only matters while credit_rcvd_o is high
  always_ff @(posedge clk_i) begin
    credit_rcvd_cnt_o <= frame_i.credit;
  end

endmodule

// ==== design/serial_link_top.sv ====
// Serial link top: link-layer controllers wired to the serializer and deserializer
module serial_link_top import serial_link_pkg::*, serial_phy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  clk_div_t  cfg_clk_div_i,
  // User transmit stream
  input  data_t     tx_data_i,
  input  logic      tx_valid_i,
  output logic      tx_ready_o,
  // User receive stream
  output data_t     rx_data_o,
  output logic      rx_valid_o,
  input  logic      rx_ready_i,
  // Off-chip pins
  output phy_pins_t phy_o,
  input  phy_pins_t phy_i
);

  frame_t  tx_frame;
  logic    tx_frame_valid;
  logic    tx_frame_ready;
  frame_t  rx_frame;
  logic    rx_frame_valid;
  logic    credit_ret;
  logic    credit_rcvd;
  credit_t credit_rcvd_cnt;

  //////////////////////////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////////////////////////

  serial_link_tx_ctrl i_tx_ctrl (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .tx_data_i         ( tx_data_i       ),
    .tx_valid_i        ( tx_valid_i      ),
    .tx_ready_o        ( tx_ready_o      ),
    .credit_ret_i      ( credit_ret      ),
    .credit_rcvd_i     ( credit_rcvd     ),
    .credit_rcvd_cnt_i ( credit_rcvd_cnt ),
    .frame_o           ( tx_frame        ),
    .frame_valid_o     ( tx_frame_valid  ),
    .frame_ready_i     ( tx_frame_ready  )
  );

  serial_phy_serializer i_serializer (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .cfg_clk_div_i ( cfg_clk_div_i  ),
    .frame_i       ( tx_frame       ),
    .frame_valid_i ( tx_frame_valid ),
    .frame_ready_o ( tx_frame_ready ),
    .phy_o         ( phy_o          )
  );

  //////////////////////////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////////////////////////

  serial_phy_deserializer i_deserializer (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .phy_i         ( phy_i          ),
    .frame_o       ( rx_frame       ),
    .frame_valid_o ( rx_frame_valid )
  );

  serial_link_rx_ctrl i_rx_ctrl (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .frame_i           ( rx_frame        ),
    .frame_valid_i     ( rx_frame_valid  ),
    .rx_data_o         ( rx_data_o       ),
    .rx_valid_o        ( rx_valid_o      ),
    .rx_ready_i        ( rx_ready_i      ),
    .credit_ret_o      ( credit_ret      ),
    .credit_rcvd_o     ( credit_rcvd     ),
    .credit_rcvd_cnt_o ( credit_rcvd_cnt )
  );

endmodule

// ==== design/serial_link_tx_ctrl.sv ====
// Transmit controller: frame builder, transmit credit counter and owed credits
`include "serial_link_consts.svh"

module serial_link_tx_ctrl import serial_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // User stream
  input  data_t   tx_data_i,
  input  logic    tx_valid_i,
  output logic    tx_ready_o,
  // From the receive controller
  input  logic    credit_ret_i,
  input  logic    credit_rcvd_i,
  input  credit_t credit_rcvd_cnt_i,
  // To the serializer
  output frame_t  frame_o,
  output logic    frame_valid_o,
  input  logic    frame_ready_i
);

  credit_t tx_credit_q;
  credit_t tx_credit_d;
  credit_t owed_q;
  credit_t owed_d;
  logic    send_data;
  logic    send_credit;

  // Data needs a free slot at the far end
  assign tx_ready_o = (tx_credit_q != '0) && frame_ready_i;
  assign send_data  = tx_valid_i && tx_ready_o;

  // Owed credits go out alone whenever no data frame leaves,
  // otherwise a blocked sender could never get its credits back
  assign send_credit   = !send_data && (owed_q != '0) && frame_ready_i;
  assign frame_valid_o = send_data || send_credit;

  always_comb begin
    frame_o        = '0;
    frame_o.credit = owed_q;
    if (send_data) begin
      frame_o.data = tx_data_i;
      frame_o.tag  = TAG_DATA;
    end else begin
      frame_o.tag  = TAG_CREDIT;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit bookkeeping
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_credit_d = tx_credit_q;
    if (send_data) begin
      tx_credit_d = tx_credit_d - 1'b1;
    end
    if (credit_rcvd_i) begin
      tx_credit_d = tx_credit_d + credit_rcvd_cnt_i;
    end
  end

  // Every frame carries all owed credits, so a send clears the counter
  always_comb begin
    owed_d = owed_q;
    if (frame_valid_o) begin
      owed_d = '0;
    end
    if (credit_ret_i && (owed_d != '1)) begin
      owed_d = owed_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_credit_q <= credit_t'(`SL_NUM_CREDITS);
      owed_q      <= '0;
    end else begin
      tx_credit_q <= tx_credit_d;
      owed_q      <= owed_d;
    end
  end

endmodule

// ==== design/serial_phy_deserializer.sv ====
// Deserializer: pin synchronizer, forwarded clock edge detect and frame reassembly
`include "serial_link_consts.svh"

module serial_phy_deserializer import serial_link_pkg::*, serial_phy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  phy_pins_t phy_i,
  output frame_t    frame_o,
  output logic      frame_valid_o
);

  localparam int ShiftBits = `SL_FRAME_SPLITS * `SL_NUM_LANES;
  localparam int IdxBits   = $clog2(`SL_FRAME_SPLITS);

  typedef logic [IdxBits-1:0] idx_t;

  localparam idx_t LastChunk = idx_t'(`SL_FRAME_SPLITS - 1);

  phy_pins_t            sync1_q;
  phy_pins_t            sync2_q;
  logic                 clk_prev_q;
  logic                 clk_rise;
  idx_t                 chunk_cnt_q;
  logic [ShiftBits-1:0] frame_bits_q;

  //////////////////////////////////////////////////////////////////////
  // Pin synchronizer
  //////////////////////////////////////////////////////////////////////

  // Lanes travel with the clock so both see the same delay
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      clk_prev_q <= 1'b0;
    end else begin
      sync1_q    <= phy_i;
      sync2_q    <= sync1_q;
      clk_prev_q <= sync2_q.fwd_clk;
    end
  end

  assign clk_rise = sync2_q.fwd_clk && !clk_prev_q;

  //////////////////////////////////////////////////////////////////////
  // Frame reassembly
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chunk_cnt_q   <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= clk_rise && (chunk_cnt_q == LastChunk);
      if (clk_rise) begin
        chunk_cnt_q <= (chunk_cnt_q == LastChunk) ? '0 : chunk_cnt_q + 1'b1;
      end
    end
  end

  // First chunk ends up at the bottom after the last one arrives
  always_ff @(posedge clk_i) begin
    if (clk_rise) begin
      frame_bits_q <= {sync2_q.lanes, frame_bits_q[ShiftBits-1:`SL_NUM_LANES]};
    end
  end

  assign frame_o = frame_t'(frame_bits_q[$bits(frame_t)-1:0]);

endmodule

// ==== design/serial_phy_pkg.sv ====
// Physical-layer types: lane chunk, divider value and pin bundle
`include "serial_link_consts.svh"

package serial_phy_pkg;

  // One sample across all lanes
  typedef logic [`SL_NUM_LANES-1:0] chunk_t;

  // Half period of the forwarded clock in core cycles, 0 acts as 1
  typedef logic [`SL_CLK_DIV_BITS-1:0] clk_div_t;

  // Pins of one direction
  typedef struct packed {
    logic   fwd_clk;
    chunk_t lanes;
  } phy_pins_t;

endpackage

// ==== design/serial_phy_serializer.sv ====
// Serializer: frame queue, chunk splitting, clock divider and forwarded clock
`include "serial_link_consts.svh"

module serial_phy_serializer import serial_link_pkg::*, serial_phy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  clk_div_t  cfg_clk_div_i,
  input  frame_t    frame_i,
  input  logic      frame_valid_i,
  output logic      frame_ready_o,
  output phy_pins_t phy_o
);

  localparam int ShiftBits = `SL_FRAME_SPLITS * `SL_NUM_LANES;
  localparam int PadBits   = ShiftBits - $bits(frame_t);
  localparam int IdxBits   = $clog2(`SL_FRAME_SPLITS);

  typedef logic [IdxBits-1:0] idx_t;

  localparam idx_t LastChunk = idx_t'(`SL_FRAME_SPLITS - 1);

  frame_t                 fifo_head;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   load;
  logic                   frame_end;
  logic                   div_wrap;
  clk_div_t               div_last;
  clk_div_t               div_cnt_q;
  idx_t                   chunk_idx_q;
  logic                   busy_q;
  logic                   phase_q;
  logic [ShiftBits-1:0]   shift_q;

  assign frame_ready_o = !fifo_full;

  serial_link_fifo #(
    .item_t ( frame_t           ),
    .Depth  ( `SL_TX_FIFO_DEPTH )
  ) i_tx_fifo (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .push_i  ( frame_valid_i ),
    .data_i  ( frame_i       ),
    .full_o  ( fifo_full     ),
    .pop_i   ( load          ),
    .data_o  ( fifo_head     ),
    .empty_o ( fifo_empty    )
  );

  //////////////////////////////////////////////////////////////////////
  // Chunk timing
  //////////////////////////////////////////////////////////////////////

  // A divider of 0 runs like 1
  assign div_last  = (cfg_clk_div_i == '0) ? '0 : cfg_clk_div_i - 1'b1;
  assign div_wrap  = (div_cnt_q == div_last);
  assign frame_end = busy_q && phase_q && div_wrap && (chunk_idx_q == LastChunk);

  // Next frame follows the last chunk without a gap
  assign load = !fifo_empty && (!busy_q || frame_end);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      phase_q     <= 1'b0;
      div_cnt_q   <= '0;
      chunk_idx_q <= '0;
    end else if (load) begin
      busy_q      <= 1'b1;
      phase_q     <= 1'b0;
      div_cnt_q   <= '0;
      chunk_idx_q <= '0;
    end else if (busy_q) begin
      div_cnt_q <= div_wrap ? '0 : div_cnt_q + 1'b1;
      if (div_wrap) begin
        phase_q <= !phase_q;
        // High phase done, move on to the next chunk
        if (phase_q) begin
          chunk_idx_q <= chunk_idx_q + 1'b1;
          if (chunk_idx_q == LastChunk) begin
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  // Lowest chunk sits on the lanes
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= {{PadBits{1'b0}}, fifo_head};
    end else if (busy_q && phase_q && div_wrap) begin
      shift_q <= shift_q >> `SL_NUM_LANES;
    end
  end

  assign phy_o.fwd_clk = phase_q;
  assign phy_o.lanes   = shift_q[`SL_NUM_LANES-1:0];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the loopback testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary -f verilog.f --top-module tb_serial_link &&
./obj_dir/Vtb_serial_link ||
{
  echo "Simulation build or run failed"
  exit 1
}

// ==== tb/serial_link_cases.txt ====
// Each line holds a divider, a data word and receive stall cycles in hex
// The divider changes only between groups of lines
01 a5c3 0000
01 0001 0000
01 ffff 0002
01 8000 0000
01 1234 0000
01 7e81 0005
00 0000 0000
00 c0de 0000
00 5a5a 0010
00 beef 0000
03 0f0f 00c8
03 f0f0 0000
03 3c3c 0000
03 c3c3 0000
03 6996 0000
03 9669 0000
0c 1111 0000
0c 2222 0000
0c 4444 0000
0c 8888 0000
0c dead 0040
02 0102 0000
02 0304 0000
02 fedc 0000
02 ba98 0003
02 7654 0000

// ==== tb/tb_serial_link.sv ====
// Loopback testbench with clock, reset, case file stimulus, driver, monitor, checks and watchdog
`include "serial_link_consts.svh"

module tb_serial_link import serial_link_pkg::*, serial_phy_pkg::*;;

  localparam int NumCases  = 26;
  localparam int Entries   = 3 * NumCases;
  localparam int EntryBits = $clog2(Entries);

  logic      clk;
  logic      rst_n_i;
  clk_div_t  cfg_clk_div_i;
  data_t     tx_data_i;
  logic      tx_valid_i;
  logic      tx_ready_o;
  data_t     rx_data_o;
  logic      rx_valid_o;
  logic      rx_ready_i;
  phy_pins_t phy_pins;

  // Three entries per case, in the order divider, word, stall cycles
  logic [15:0] case_mem [Entries];
  bit          cases_loaded;
  bit          reset_checked;
  int          accepted_cnt;
  int          popped_cnt;
  int          limit_cycles;

  // Pins wired straight back into the receiver
  serial_link_top dut_i (
    .clk_i         ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .cfg_clk_div_i ( cfg_clk_div_i ),
    .tx_data_i     ( tx_data_i     ),
    .tx_valid_i    ( tx_valid_i    ),
    .tx_ready_o    ( tx_ready_o    ),
    .rx_data_o     ( rx_data_o     ),
    .rx_valid_o    ( rx_valid_o    ),
    .rx_ready_i    ( rx_ready_i    ),
    .phy_o         ( phy_pins      ),
    .phy_i         ( phy_pins      )
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] case_entry(int idx, int field);
    return case_mem[EntryBits'(3 * idx + field)];
  endfunction

  function automatic clk_div_t div_of_case(int idx);
    return clk_div_t'(case_entry(idx, 0));
  endfunction

  function automatic data_t word_of_case(int idx);
    return data_t'(case_entry(idx, 1));
  endfunction

  function automatic int stall_of_case(int idx);
    return int'(case_entry(idx, 2));
  endfunction

  function automatic int effective_div(clk_div_t div);
    return (div == '0) ? 1 : int'(div);
  endfunction

  // Galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  task automatic take_random_bit(inout logic [15:0] state, output logic rnd);
    rnd   = state[0];
    state = lfsr_step(state);
  endtask

  task automatic end_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      end_with_failure();
    end
  endtask

  // Every word delivered and no forwarded clock pulse for a while
  task automatic wait_link_idle();
    int quiet;
    quiet = 0;
    while ((popped_cnt != accepted_cnt) || (quiet < 2 * effective_div(cfg_clk_div_i) + 8)) begin
      @(negedge clk);
      if (phy_pins.fwd_clk || (popped_cnt != accepted_cnt)) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, reset and end of run
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : main_seq
    int max_div;
    int total_stall;
    rst_n_i = 1'b0;
    $readmemh("tb/serial_link_cases.txt", case_mem);
    max_div     = 1;
    total_stall = 0;
    for (int i = 0; i < NumCases; i++) begin
      if (effective_div(div_of_case(i)) > max_div) begin
        max_div = effective_div(div_of_case(i));
      end
      total_stall += stall_of_case(i);
    end
    // A word may cost a data frame and a credit frame
    limit_cycles = NumCases * (4 * `SL_FRAME_SPLITS * max_div + 100) + total_stall + 40;
    cases_loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    check_value("rx_valid_o", 32'(rx_valid_o), 0);
    check_value("phy_o.fwd_clk", 32'(phy_pins.fwd_clk), 0);
    check_value("tx_ready_o", 32'(tx_ready_o), 1);
    reset_checked = 1'b1;
    wait (popped_cnt == NumCases);
    wait_link_idle();
    if (rx_valid_o) begin
      $display("A word appeared at rx_data_o after the last case was received");
      end_with_failure();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    wait (cases_loaded);
    repeat (limit_cycles) @(posedge clk);
    $display("Timed out after %0d cycles before all cases completed", limit_cycles);
    end_with_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Driver, monitor and forwarded clock check
  //////////////////////////////////////////////////////////////////////

  initial begin : driver
    logic [15:0] lfsr;
    logic        gap_a;
    logic        gap_b;
    logic        offering;
    int          idx;
    lfsr          = 16'd80;
    offering      = 1'b0;
    idx           = 0;
    tx_valid_i    = 1'b0;
    tx_data_i     = '0;
    cfg_clk_div_i = '0;
    wait (cases_loaded);
    cfg_clk_div_i = div_of_case(0);
    wait (reset_checked);
    while (idx < NumCases) begin
      @(negedge clk);
      // All credits in use means no new word may enter
      if (accepted_cnt - popped_cnt >= `SL_NUM_CREDITS) begin
        check_value("tx_ready_o", 32'(tx_ready_o), 0);
      end
      if (!offering) begin
        tx_valid_i = 1'b0;
        // Divider changes only on a quiet link
        if (div_of_case(idx) != cfg_clk_div_i) begin
          wait_link_idle();
          cfg_clk_div_i = div_of_case(idx);
        end
        take_random_bit(lfsr, gap_a);
        take_random_bit(lfsr, gap_b);
        if (!(gap_a && gap_b)) begin
          tx_valid_i = 1'b1;
          tx_data_i  = word_of_case(idx);
          offering   = 1'b1;
        end
      end
      // Ready comes from flops only and holds until the next rising edge
      if (offering && tx_ready_o) begin
        accepted_cnt++;
        idx++;
        offering = 1'b0;
      end
    end
    @(negedge clk);
    tx_valid_i = 1'b0;
  end

  initial begin : monitor
    logic [15:0] lfsr;
    logic        hold_a;
    logic        hold_b;
    logic        popped;
    int          stall_left;
    lfsr       = 16'd80;
    rx_ready_i = 1'b0;
    wait (reset_checked);
    for (int k = 0; k < NumCases; k++) begin
      stall_left = stall_of_case(k);
      popped     = 1'b0;
      while (!popped) begin
        @(negedge clk);
        if (stall_left > 0) begin
          rx_ready_i = 1'b0;
          stall_left--;
        end else begin
          take_random_bit(lfsr, hold_a);
          take_random_bit(lfsr, hold_b);
          rx_ready_i = !(hold_a && hold_b);
          if (rx_ready_i && rx_valid_o) begin
            check_value("rx_data_o", 32'(rx_data_o), 32'(word_of_case(k)));
            popped_cnt++;
            popped = 1'b1;
          end
        end
      end
    end
    // Any extra word stays visible at the output
    @(negedge clk);
    rx_ready_i = 1'b0;
  end

  initial begin : fwd_clk_check
    int high_cnt;
    high_cnt = 0;
    forever begin
      @(negedge clk);
      if (phy_pins.fwd_clk) begin
        high_cnt++;
      end else if (high_cnt != 0) begin
        // High phase lasts div cycles and a divider of 0 acts as 1
        check_value("phy_o.fwd_clk high cycles", high_cnt, effective_div(cfg_clk_div_i));
        high_cnt = 0;
      end
    end
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/serial_link_pkg.sv
design/serial_phy_pkg.sv
design/serial_link_fifo.sv
design/serial_link_tx_ctrl.sv
design/serial_link_rx_ctrl.sv
design/serial_phy_serializer.sv
design/serial_phy_deserializer.sv
design/serial_link_top.sv
tb/tb_serial_link.sv
